//--- bench/pov_chk.sv
`default_nettype none

`include "pov_macros.svh"

// Protocol rules on the driver pins of the shifter
module pov_chk
    import pov_pkg::*;
(
    input logic      clk,
    input logic      nrst,
    input drv_pins_t sin,
    input logic      shift_en,
    input logic      lat
);
    timeunit 1ns;
    timeprecision 100ps;

    // Counts the blanking cycles that follow each latch
    logic [2:0] blank_left;
    // High for each pair whose two pins disagree
    pair_word_t pair_diff;
    // Failures of each rule so far
    int pair_fails = 0;
    int lat_fails = 0;
    int blank_fails = 0;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            blank_left <= '0;
        end else if (lat) begin
            blank_left <= 3'(`POV_BLANK);
        end else if (blank_left != '0) begin
            blank_left <= blank_left - 1'b1;
        end
    end

    always_comb begin
        for (int p = 0; p < `POV_PAIRS; p++) begin
            pair_diff[p] = sin[2*p] ^ sin[2*p+1];
        end
    end

    // Facing drivers of a pair must show the same pixel
    a_pair_equal: assert property (@(posedge clk) disable iff (!nrst)
        shift_en |-> (pair_diff == '0))
        else begin
            pair_fails++;
            $error("Pins of a pair differ during a shift, pins %b", sin);
        end

    a_lat_after_shift: assert property (@(posedge clk) disable iff (!nrst)
        lat |-> $past(shift_en))
        else begin
            lat_fails++;
            $error("Latch without a shift on the cycle before");
        end

    a_blank_hold: assert property (@(posedge clk) disable iff (!nrst)
        (blank_left != '0) |-> !shift_en)
        else begin
            blank_fails++;
            $error("Shift inside the blanking interval");
        end

endmodule

bind driver_shifter pov_chk u_pov_chk (
    .clk      (clk),
    .nrst     (nrst),
    .sin      (sin),
    .shift_en (shift_en),
    .lat      (lat)
);

`default_nettype wire

//--- bench/pov_stim.txt
// Words 00 to 5f: RAM image, 15-bit RGB pixels with blue in the low bits
// From @60: commands, high byte 01 sync, 02 stop, 03 idle; low byte slice; 0000 ends
0000 7fff 001f 03e0 7c00 1234 4321 2aaa
5555 0f0f 70f0 3c3c 43c3 6666 1999 7e01
01fe 2468 5bd7 0c31 73ce 4a52 35ad 0421
7bde 18c6 6739 2d6b 52b4 1ef7 6108 3210
4cef 0bad 7ace 2f00 50ff 13f1 6c0e 3579
4a86 77bb 0844 5e22 21dd 6e6e 1191 3003
0cfc 7113 4f4f 30b0 6a5a 15a5 7a01 05fe
3ee1 411e 2bcd 5432 0def 7210 1357 6ca8
48d1 372e 6f0f 10f0 2c4b 53b4 04f6 7b09
3f3f 40c0 1b2d 64d2 5876 2789 0ff0 700f
2468 5b97 36c9 4936 0a0a 75f5 1c71 638e
2222 5ddd 7070 0f8f 4b6d 3492 6a1c 15e3
@60
0300 // idle: sync with stream_en low
0100 // sync slice 0
0101 // sync slice 1
0100 // sync wraps to slice 0
0201 // stop in the middle of slice 1
0101 // sync restarts slice 1
0000

//--- bench/pov_tb.sv
`default_nettype none

`include "pov_macros.svh"

module pov_tb
    import pov_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int PLANE_WORDS = `POV_LEDS * 3;
    localparam int SLICE_WORDS = `POV_MUX * `POV_PLANES * PLANE_WORDS;
    localparam int CMD_BASE = 'h60;
    localparam int PAD = `POV_PLANES - `POV_COLOR_BITS;
    // Panel wiring that gives the row driven by each LED
    localparam int RG_TABLE [`POV_LEDS] = '{2, 3, 1, 0, 6, 7, 5, 4};
    localparam int B_TABLE [`POV_LEDS] = '{0, 1, 4, 5, 2, 3, 6, 7};

    logic clk;
    logic nrst;
    logic wr_en;
    ram_addr_t wr_addr;
    pixel_t wr_data;
    logic stream_en;
    logic position_sync;
    drv_pins_t sin;
    logic shift_en;
    logic lat;

    logic [15:0] stim [128];
    pair_word_t expected [$];
    drv_pins_t got_pins [$];
    int lat_marks [$];
    int lat_count = 0;
    int errors = 0;
    int test_errors = 0;
    int cycles = 0;
    int cycle_limit = 0;

    pov_display_top u_pov_display_top (
        .clk           (clk),
        .nrst          (nrst),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .stream_en     (stream_en),
        .position_sync (position_sync),
        .sin           (sin),
        .shift_en      (shift_en),
        .lat           (lat)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    // Record every shifted word and where in the stream each latch falls
    always @(posedge clk) begin
        if (nrst && shift_en) begin
            got_pins.push_back(sin);
        end
        if (nrst && lat) begin
            lat_count++;
            lat_marks.push_back(got_pins.size());
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Run stopped: the tests did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $finish;
        end
    end

    // Builds the expected words of one slice from the stim RAM image
    task automatic build_expected(input int slice);
        int row;
        logic [15:0] px;
        pair_word_t w;
        expected.delete();
        for (int c = 0; c < `POV_MUX; c++)
            for (int pl = `POV_PLANES - 1; pl >= 0; pl--)
                for (int l = `POV_LEDS - 1; l >= 0; l--)
                    for (int k = 0; k < 3; k++) begin
                        w = '0;
                        row = (k == 0) ? B_TABLE[l] : RG_TABLE[l];
                        // Padding planes carry zeros
                        if (pl >= PAD) begin
                            for (int p = 0; p < `POV_PAIRS; p++) begin
                                px = stim[slice * `POV_IMAGE_WORDS + row * `POV_ROW_WORDS
                                          + p * `POV_MUX + c];
                                w[p] = px[k * `POV_COLOR_BITS + pl - PAD];
                            end
                        end
                        expected.push_back(w);
                    end
    endtask

    function automatic pair_word_t pair_bits(input drv_pins_t pins);
        pair_word_t w;
        for (int p = 0; p < `POV_PAIRS; p++) begin
            w[p] = pins[2*p];
        end
        return w;
    endfunction

    function automatic drv_pins_t duplicate_pairs(input pair_word_t w);
        drv_pins_t pins;
        for (int p = 0; p < `POV_PAIRS; p++) begin
            pins[2*p+1 -: 2] = {2{w[p]}};
        end
        return pins;
    endfunction

    // Sum of the failures seen by the bound protocol checker
    function automatic int assertion_failures();
        return u_pov_display_top.u_driver_shifter.u_pov_chk.pair_fails
            + u_pov_display_top.u_driver_shifter.u_pov_chk.lat_fails
            + u_pov_display_top.u_driver_shifter.u_pov_chk.blank_fails;
    endfunction

    task automatic check_word(input pair_word_t got, input pair_word_t exp, input int idx);
        if (got !== exp) begin
            test_errors++;
            $display("ERROR %0t: word %0d is %b, expected %b", $time, idx, got, exp);
        end
    endtask

    task automatic check_pins(input drv_pins_t got, input drv_pins_t exp, input int idx);
        if (got !== exp) begin
            test_errors++;
            $display("ERROR %0t: pins of word %0d are %b, expected %b", $time, idx, got, exp);
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            test_errors++;
            $display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compare_stream(input int n);
        for (int i = 0; i < n && i < got_pins.size(); i++) begin
            check_word(pair_bits(got_pins[i]), expected[i], i);
            check_pins(got_pins[i], duplicate_pairs(expected[i]), i);
        end
    endtask

    // Clears the capture between edges so it never races the recorder
    task automatic clear_capture();
        @(negedge clk);
        got_pins.delete();
        lat_marks.delete();
        lat_count = 0;
    endtask

    task automatic pulse_sync(input logic enable);
        @(posedge clk);
        stream_en <= enable;
        position_sync <= 1'b1;
        @(posedge clk);
        position_sync <= 1'b0;
    endtask

    task automatic stream_slice(input int slice);
        build_expected(slice);
        clear_capture();
        pulse_sync(1'b1);
        while (got_pins.size() < SLICE_WORDS) @(negedge clk);
        // The last latch and any stray word would show up within this window
        repeat (3 * `POV_BLANK) @(negedge clk);
        check_count(got_pins.size(), SLICE_WORDS, "word count");
        compare_stream(SLICE_WORDS);
        check_count(lat_count, 2 * `POV_PLANES, "latch count");
        for (int i = 0; i < lat_marks.size(); i++) begin
            check_count(lat_marks[i], PLANE_WORDS * (i + 1), "words before latch");
        end
    endtask

    task automatic abort_slice(input int slice);
        int drop_size;
        build_expected(slice);
        clear_capture();
        pulse_sync(1'b1);
        while (got_pins.size() < 100) @(negedge clk);
        @(posedge clk);
        stream_en <= 1'b0;
        @(negedge clk);
        drop_size = got_pins.size();
        repeat (10) @(negedge clk);
        if (got_pins.size() > drop_size + 3) begin
            test_errors++;
            $display("ERROR %0t: %0d words after stream_en dropped", $time,
                     got_pins.size() - drop_size);
        end
        compare_stream(got_pins.size());
    endtask

    task automatic sync_disabled();
        clear_capture();
        pulse_sync(1'b0);
        repeat (50) @(negedge clk);
        check_count(got_pins.size(), 0, "words while disabled");
        check_count(lat_count, 0, "latches while disabled");
    endtask

    initial begin
        int n_cmd;
        int tested;
        int chk_before;
        logic [15:0] cmd;
        nrst = 1'b0;
        wr_en = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        stream_en = 1'b0;
        position_sync = 1'b0;
        $readmemh("bench/pov_stim.txt", stim);
        tested = 0;
        for (int i = CMD_BASE; i < 128 && stim[i] != 16'h0000; i++) begin
            if (stim[i][15:8] != 8'h03) tested++;
        end
        cycle_limit = 4 * (tested * 2 * `POV_PLANES * (24 + `POV_BLANK + 2) + 100);
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        // Load both slices through the host port
        for (int i = 0; i < `POV_RAM_WORDS; i++) begin
            @(posedge clk);
            wr_en <= 1'b1;
            wr_addr <= ram_addr_t'(i);
            wr_data <= pixel_t'(stim[i]);
        end
        @(posedge clk);
        wr_en <= 1'b0;
        n_cmd = 0;
        while (CMD_BASE + n_cmd < 128 && stim[CMD_BASE + n_cmd] != 16'h0000) begin
            cmd = stim[CMD_BASE + n_cmd];
            test_errors = 0;
            chk_before = assertion_failures();
            case (cmd[15:8])
                8'h01: stream_slice(int'(cmd[7:0]));
                8'h02: abort_slice(int'(cmd[7:0]));
                default: sync_disabled();
            endcase
            test_errors += assertion_failures() - chk_before;
            errors += test_errors;
            $display("Test %0d, command %h, slice %0d: %s with %0d errors", n_cmd + 1,
                     cmd[15:8], cmd[7:0], (test_errors == 0) ? "passed" : "failed",
                     test_errors);
            n_cmd++;
        end
        $display("Tests run: %0d, errors: %0d", n_cmd, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/driver_shifter.sv
`default_nettype none

`include "pov_macros.svh"

module driver_shifter
    import pov_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    // Plane words from the framebuffer
    drv_stream_if.snk  rx,
    // Serial data for all drivers
    output drv_pins_t  sin,
    output logic       shift_en,
    output logic       lat
);

    localparam int BLANK_W = $clog2(`POV_BLANK);

    sh_state_t state;
    logic [BLANK_W-1:0] blank_cnt;
    logic xfer;

    assign xfer = rx.valid && rx.ready;

    // Words are only taken while no latch or blanking is pending
    assign rx.ready = (state == SH_RUN);

    // Both drivers of a pair face each other and get the same bit
    always_ff @(posedge clk) begin
        if (xfer) begin
            for (int p = 0; p < `POV_PAIRS; p++) begin
                sin[2*p] <= rx.word[p];
                sin[2*p+1] <= rx.word[p];
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= SH_RUN;
            blank_cnt <= '0;
            shift_en <= 1'b0;
            lat <= 1'b0;
        end else begin
            // One shift pulse for each accepted word
            shift_en <= xfer;
            lat <= 1'b0;
            case (state)
                SH_RUN: begin
                    if (xfer && rx.plane_end) begin
                        state <= SH_LATCH;
                    end
                end
                SH_LATCH: begin
                    // The last bit of the plane shifts now, latch on the next cycle
                    lat <= 1'b1;
                    blank_cnt <= BLANK_W'(`POV_BLANK - 1);
                    state <= SH_BLANK;
                end
                default: begin
                    // Hold off new words until the drivers have settled
                    blank_cnt <= blank_cnt - 1'b1;
                    if (blank_cnt == '0) begin
                        state <= SH_RUN;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtl/drv_stream_if.sv
`default_nettype none

// Bit-plane stream from the framebuffer to the driver shifter
interface drv_stream_if
    import pov_pkg::*;
();

    // One bit per driver pair
    pair_word_t word;
    logic valid;
    // High on the last word of a plane
    logic plane_end;
    // Low while the shifter latches and blanks
    logic ready;

    modport src (output word, output valid, output plane_end, input ready);

    modport snk (input word, input valid, input plane_end, output ready);

endinterface

`default_nettype wire

//--- rtl/framebuffer.sv
`default_nettype none

`include "pov_macros.svh"

module framebuffer
    import pov_pkg::*;
(
    input  logic       clk,
    input  logic       nrst,
    input  logic       stream_en,
    input  logic       position_sync,
    // Slice RAM read port
    output ram_addr_t  rd_addr,
    input  pixel_t     rd_data,
    // Plane words towards the shifter
    drv_stream_if.src  tx
);

    localparam int COL_W = $clog2(`POV_MUX);
    localparam int SLICE_W = $clog2(`POV_SLICES);
    // Planes below this one are the zero padding
    localparam logic [2:0] PAD_PLANES = 3'(`POV_PLANES - `POV_COLOR_BITS);
    // Colours go out blue, green, red
    localparam logic [1:0] C_BLUE = 2'd0;
    localparam logic [1:0] C_RED = 2'd2;

    // Wiring of the driver outputs to the image rows
    localparam logic [2:0] RG_MAP [`POV_LEDS] = '{
        3'd2, 3'd3, 3'd1, 3'd0, 3'd6, 3'd7, 3'd5, 3'd4
    };
    localparam logic [2:0] B_MAP [`POV_LEDS] = '{
        3'd0, 3'd1, 3'd4, 3'd5, 3'd2, 3'd3, 3'd6, 3'd7
    };

    fb_state_t state;
    logic [SLICE_W-1:0] slice_cnt;

    // Buffer b always holds column b, so the column counter also picks the half
    pixel_t col_buf [`POV_MUX][`POV_BUF_WORDS];

    // Fill side of the double buffer
    logic fill_busy;
    logic [COL_W-1:0] fill_col;
    buf_idx_t fill_cnt;
    buf_idx_t issue_idx;
    logic fill_done;
    logic fill_start;
    ram_addr_t slice_base;

    // Stream side counters
    logic [COL_W-1:0] col;
    logic [2:0] plane;
    logic [2:0] led;
    logic [1:0] color;
    logic xfer;
    logic [2:0] led_row;
    logic [3:0] bit_sel;
    pair_word_t word;

    assign xfer = tx.valid && tx.ready;

    // A new column fetch starts on a sync, and column 1 follows right after the prime
    assign fill_start = stream_en
        && ((state == FB_IDLE && position_sync) || (state == FB_PRIME && fill_done));
    // The last count only writes the final word from the RAM pipeline
    assign fill_done = fill_busy && (fill_cnt == buf_idx_t'(`POV_BUF_WORDS));

    // Stride-2 walk: entry row*3+pair sits at row*6+pair*2 in the slice
    assign slice_base = ram_addr_t'(slice_cnt) * ram_addr_t'(`POV_IMAGE_WORDS);
    assign issue_idx = (fill_cnt < buf_idx_t'(`POV_BUF_WORDS)) ? fill_cnt : '0;
    assign rd_addr = slice_base + ram_addr_t'(fill_col) + (ram_addr_t'(issue_idx) << 1);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            fill_busy <= 1'b0;
            fill_cnt <= '0;
            fill_col <= '0;
        end else if (!stream_en) begin
            fill_busy <= 1'b0;
            fill_cnt <= '0;
        end else if (fill_start) begin
            fill_busy <= 1'b1;
            fill_cnt <= '0;
            // The prime fetches column 0, the refill during streaming column 1
            fill_col <= COL_W'(state != FB_IDLE);
        end else if (fill_done) begin
            fill_busy <= 1'b0;
        end else if (fill_busy) begin
            fill_cnt <= fill_cnt + 1'b1;
        end
    end

    // rd_data lags the address by one cycle, so it lands one entry behind the count
    always_ff @(posedge clk) begin
        if (fill_busy && fill_cnt != '0) begin
            col_buf[fill_col][fill_cnt - 1'b1] <= rd_data;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= FB_IDLE;
            slice_cnt <= '0;
            col <= '0;
            plane <= 3'(`POV_PLANES - 1);
            led <= 3'(`POV_LEDS - 1);
            color <= C_BLUE;
        end else if (!stream_en) begin
            state <= FB_IDLE;
        end else begin
            case (state)
                FB_IDLE: begin
                    // Every slice starts at column 0, plane 6, LED 7, blue
                    col <= '0;
                    plane <= 3'(`POV_PLANES - 1);
                    led <= 3'(`POV_LEDS - 1);
                    color <= C_BLUE;
                    if (position_sync) begin
                        state <= FB_PRIME;
                    end
                end
                FB_PRIME: begin
                    if (fill_done) begin
                        state <= FB_STREAM;
                    end
                end
                default: begin
                    if (xfer) begin
                        color <= color + 1'b1;
                        if (color == C_RED) begin
                            color <= C_BLUE;
                            led <= led - 1'b1;
                            if (led == '0) begin
                                led <= 3'(`POV_LEDS - 1);
                                plane <= plane - 1'b1;
                                if (plane == '0) begin
                                    // Column done, swap to the half filled meanwhile
                                    plane <= 3'(`POV_PLANES - 1);
                                    col <= col + 1'b1;
                                    if (col == COL_W'(`POV_MUX - 1)) begin
                                        col <= '0;
                                        state <= FB_IDLE;
                                        slice_cnt <= slice_cnt + 1'b1;
                                        if (slice_cnt == SLICE_W'(`POV_SLICES - 1)) begin
                                            slice_cnt <= '0;
                                        end
                                    end
                                end
                            end
                        end
                    end
                end
            endcase
        end
    end

    // Blue has its own wiring, green and red share one table
    assign led_row = (color == C_BLUE) ? B_MAP[led] : RG_MAP[led];
    // Colour field base plus the bit of this plane, MSB first
    assign bit_sel = 4'(color * `POV_COLOR_BITS) + 4'(plane - PAD_PLANES);

    always_comb begin
        word = '0;
        // Padding planes stay zero
        if (plane >= PAD_PLANES) begin
            for (int p = 0; p < `POV_PAIRS; p++) begin
                word[p] = col_buf[col][buf_idx_t'(p) + buf_idx_t'(`POV_PAIRS * led_row)][bit_sel];
            end
        end
    end

    // The counters only move on a transfer, so the word holds under back-pressure
    assign tx.word = word;
    assign tx.valid = (state == FB_STREAM);
    assign tx.plane_end = (led == '0) && (color == C_RED);

endmodule

`default_nettype wire

//--- rtl/pov_display_top.sv
`default_nettype none

module pov_display_top
    import pov_pkg::*;
(
    input  logic      clk,
    input  logic      nrst,
    // Host port into the slice RAM
    input  logic      wr_en,
    input  ram_addr_t wr_addr,
    input  pixel_t    wr_data,
    // Display control
    input  logic      stream_en,
    input  logic      position_sync,
    // LED driver pins
    output drv_pins_t sin,
    output logic      shift_en,
    output logic      lat
);

    ram_addr_t rd_addr;
    pixel_t rd_data;

    drv_stream_if stream_if ();

    slice_ram u_slice_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // Reads one column at a time and turns it into plane words
    framebuffer u_framebuffer (
        .clk           (clk),
        .nrst          (nrst),
        .stream_en     (stream_en),
        .position_sync (position_sync),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .tx            (stream_if.src)
    );

    driver_shifter u_driver_shifter (
        .clk      (clk),
        .nrst     (nrst),
        .rx       (stream_if.snk),
        .sin      (sin),
        .shift_en (shift_en),
        .lat      (lat)
    );

endmodule

`default_nettype wire

//--- rtl/pov_macros.svh
`ifndef POV_MACROS_SVH
`define POV_MACROS_SVH

// Panel geometry. Drivers face each other in pairs and show the same pixel
`define POV_PAIRS 3
// LEDs on one driver, which is also the number of image rows
`define POV_LEDS 8
// Columns multiplexed onto each driver
`define POV_MUX 2
// One image row spans every pair and every column
`define POV_ROW_WORDS 6
`define POV_IMAGE_WORDS 48
`define POV_SLICES 2
`define POV_RAM_WORDS 96
// One column for every pair, over all rows
`define POV_BUF_WORDS 24

// Colour depth and plane count, which includes two zero padding planes
`define POV_COLOR_BITS 5
`define POV_PLANES 7
// Cycles the drivers need after a latch before new data can shift in
`define POV_BLANK 4

`endif

//--- rtl/pov_pkg.sv
`default_nettype none

`include "pov_macros.svh"

package pov_pkg;

    // 15-bit RGB, blue in bits 4:0, green in 9:5, red in 14:10
    typedef logic [3*`POV_COLOR_BITS-1:0] pixel_t;

    // Address into the slice RAM
    typedef logic [$clog2(`POV_RAM_WORDS)-1:0] ram_addr_t;

    // Index into one column buffer, wide enough to also count the fill pipeline
    typedef logic [$clog2(`POV_BUF_WORDS+1)-1:0] buf_idx_t;

    // One bit for every driver pair
    typedef logic [`POV_PAIRS-1:0] pair_word_t;

    // One serial pin for every driver
    typedef logic [2*`POV_PAIRS-1:0] drv_pins_t;

    typedef enum logic [1:0] {FB_IDLE, FB_PRIME, FB_STREAM} fb_state_t;

    typedef enum logic [1:0] {SH_RUN, SH_LATCH, SH_BLANK} sh_state_t;

endpackage

`default_nettype wire

//--- rtl/slice_ram.sv
`default_nettype none

`include "pov_macros.svh"

module slice_ram
    import pov_pkg::*;
(
    input  logic      clk,
    // Host write port
    input  logic      wr_en,
    input  ram_addr_t wr_addr,
    input  pixel_t    wr_data,
    // Framebuffer read port
    input  ram_addr_t rd_addr,
    output pixel_t    rd_data
);

    // Holds every slice back to back, each slice laid out row by row
    pixel_t mem [`POV_RAM_WORDS];

    // The host writes one pixel per cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Registered read, so the pixel comes back one cycle after its address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f vlog.f --top-module pov_tb -o pov_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/pov_sim)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Done: no errors"; then
    exit 0
else
    exit 1
fi

//--- vlog.f
+incdir+rtl
rtl/pov_pkg.sv
rtl/drv_stream_if.sv
rtl/slice_ram.sv
rtl/framebuffer.sv
rtl/driver_shifter.sv
rtl/pov_display_top.sv
bench/pov_chk.sv
bench/pov_tb.sv
